// ==== run.sh ====
#!/bin/sh
# Build and run the matrix multiply slice simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
  --top-module mm_tb -f sim.f -o Vmm_tb

# The simulator exits nonzero on a fatal error, the log decides the result
./obj_dir/Vmm_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== sim.f ====
source/mm_pkg.sv
source/mm_operand_loader.sv
source/mm_operand_fifo.sv
source/mm_mac_array.sv
source/mm_top.sv
verif/mm_tb.sv

// ==== source/mm_mac_array.sv ====
// Integer MAC array
`timescale 1ns/1ps

module mm_mac_array (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           fifo_empty_i,
  input  mm_pkg::beat_t  pop_data_i,
  output logic           pop_o,
  input  logic           load_active_i,
  output mm_pkg::z_row_t z_o,
  output logic           z_valid_o,
  input  logic           z_ready_i,
  output logic           busy_o
);

  import mm_pkg::*;

  mac_state_e state_q;
  z_row_t     acc_q;
  z_row_t     sum_d;
  z_row_t     z_q;
  logic       part_q;

  // Consume a beat whenever no finished row is waiting
  assign pop_o = (state_q == MAC_ACC) && !fifo_empty_i;

  // One product per lane, sign extended before the add
  always_comb begin
    for (int j = 0; j < ARRAY_W; j++) begin
      sum_d[j] = acc_q[j] + acc_t'(pop_data_i.x) * acc_t'(pop_data_i.w[j]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MAC_ACC;
      acc_q   <= '0;
      part_q  <= 1'b0;
    end else begin
      case (state_q)
        MAC_ACC: begin
          if (pop_o) begin
            if (pop_data_i.last) begin
              // Row complete, clear for the next job
              acc_q   <= '0;
              part_q  <= 1'b0;
              state_q <= MAC_HOLD;
            end else begin
              acc_q  <= sum_d;
              part_q <= 1'b1;
            end
          end
        end
        MAC_HOLD: begin
          if (z_ready_i) begin
            state_q <= MAC_ACC;
          end
        end
        default: begin
          state_q <= MAC_ACC;
        end
      endcase
    end
  end

  // Result register, stable while parked in hold
  always_ff @(posedge clk_i) begin
    if (pop_o && pop_data_i.last) begin
      z_q <= sum_d;
    end
  end

  assign z_o       = z_q;
  assign z_valid_o = (state_q == MAC_HOLD);

  // Any work in flight anywhere in the slice
  assign busy_o = load_active_i
               || !fifo_empty_i
               || part_q
               || (state_q == MAC_HOLD);

endmodule

// ==== source/mm_operand_fifo.sv ====
// Operand beat FIFO
`timescale 1ns/1ps

module mm_operand_fifo (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           push_i,
  input  mm_pkg::beat_t  push_data_i,
  output logic           full_o,
  input  logic           pop_i,
  output mm_pkg::beat_t  pop_data_o,
  output logic           empty_o
);

  import mm_pkg::*;

  beat_t                 mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  do_push;
  logic                  do_pop;

  assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head of the queue is always visible
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy holds when both sides move together
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== source/mm_operand_loader.sv ====
// Operand loader
`timescale 1ns/1ps

module mm_operand_loader (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  mm_pkg::k_len_t  k_len_i,
  input  mm_pkg::elem_t   x_i,
  input  mm_pkg::w_row_t  w_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic            fifo_full_i,
  output logic            push_o,
  output mm_pkg::beat_t   push_data_o,
  output logic            active_o
);

  import mm_pkg::*;

  load_state_e state_q;
  k_len_t      remain_q;
  logic        beat_fire;
  logic        last_beat;

  // Beats flow only while a job is open and the FIFO has room
  assign in_ready_o = (state_q == LOAD_RUN) && !fifo_full_i;
  assign beat_fire  = in_valid_i && in_ready_o;
  assign last_beat  = (remain_q == k_len_t'(1));

  // Accepted beats go straight into the FIFO
  assign push_o           = beat_fire;
  assign push_data_o.last = last_beat;
  assign push_data_o.x    = x_i;
  assign push_data_o.w    = w_i;

  assign active_o = (state_q == LOAD_RUN);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= LOAD_IDLE;
      remain_q <= '0;
    end else begin
      case (state_q)
        LOAD_IDLE: begin
          // Start is only honoured between jobs
          if (start_i) begin
            state_q  <= LOAD_RUN;
            remain_q <= k_len_i;
          end
        end
        LOAD_RUN: begin
          if (beat_fire) begin
            remain_q <= remain_q - k_len_t'(1);
            if (last_beat) begin
              state_q <= LOAD_IDLE;
            end
          end
        end
        default: begin
          state_q <= LOAD_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== source/mm_pkg.sv ====
// Matrix multiply slice definitions
package mm_pkg;

  // Element and array geometry
  localparam int ELEM_W  = 8;
  localparam int ARRAY_W = 4;
  localparam int ACC_W   = 24;

  // Job length field, K of zero is reserved
  localparam int K_W = 8;

  // Operand FIFO sizing
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef elem_t [ARRAY_W-1:0] w_row_t;

  typedef logic signed [ACC_W-1:0] acc_t;
  typedef acc_t [ARRAY_W-1:0] z_row_t;

  typedef logic [K_W-1:0] k_len_t;

  // One operand beat as stored in the FIFO
  typedef struct packed {
    logic   last;
    elem_t  x;
    w_row_t w;
  } beat_t;

  typedef enum logic {
    LOAD_IDLE,
    LOAD_RUN
  } load_state_e;

  typedef enum logic {
    MAC_ACC,
    MAC_HOLD
  } mac_state_e;

endpackage

// ==== source/mm_top.sv ====
// Matrix multiply slice top level
`timescale 1ns/1ps

module mm_top (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            start_i,
  input  mm_pkg::k_len_t  k_len_i,
  input  mm_pkg::elem_t   x_i,
  input  mm_pkg::w_row_t  w_i,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  output mm_pkg::z_row_t  z_o,
  output logic            z_valid_o,
  input  logic            z_ready_i,
  output logic            busy_o
);

  import mm_pkg::*;

  logic  push;
  logic  pop;
  logic  fifo_full;
  logic  fifo_empty;
  logic  load_active;
  beat_t push_data;
  beat_t pop_data;

  // Producer side
  mm_operand_loader i_loader (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .start_i     ( start_i     ),
    .k_len_i     ( k_len_i     ),
    .x_i         ( x_i         ),
    .w_i         ( w_i         ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .fifo_full_i ( fifo_full   ),
    .push_o      ( push        ),
    .push_data_o ( push_data   ),
    .active_o    ( load_active )
  );

  mm_operand_fifo i_fifo (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .push_i      ( push       ),
    .push_data_i ( push_data  ),
    .full_o      ( fifo_full  ),
    .pop_i       ( pop        ),
    .pop_data_o  ( pop_data   ),
    .empty_o     ( fifo_empty )
  );

  // Consumer side
  mm_mac_array i_mac_array (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .fifo_empty_i  ( fifo_empty  ),
    .pop_data_i    ( pop_data    ),
    .pop_o         ( pop         ),
    .load_active_i ( load_active ),
    .z_o           ( z_o         ),
    .z_valid_o     ( z_valid_o   ),
    .z_ready_i     ( z_ready_i   ),
    .busy_o        ( busy_o      )
  );

endmodule

// ==== verif/mm_tb.sv ====
// Matrix multiply slice testbench
`timescale 1ns/1ps

module mm_tb;

  import mm_pkg::*;

  localparam int RAND_JOBS  = 40;
  localparam int STALL_JOBS = 30;
  localparam int MAX_K      = 256;

  logic   clk_i;
  logic   rst_n_i;
  logic   start_i;
  k_len_t k_len_i;
  elem_t  x_i;
  w_row_t w_i;
  logic   in_valid_i;
  logic   in_ready_o;
  z_row_t z_o;
  logic   z_valid_o;
  logic   z_ready_i;
  logic   busy_o;

  integer seed;
  int     total_beats;
  int     k_plan [RAND_JOBS + STALL_JOBS];
  elem_t  job_xs [MAX_K];
  w_row_t job_ws [MAX_K];

  // Job history, consumed in order by the monitor
  int     k_hist [$];
  elem_t  x_hist [$];
  w_row_t w_hist [$];

  int     jobs_issued;
  int     results_taken = 0;
  int     outstanding = 0;
  logic   job_open;
  logic   z_parked = 1'b0;
  z_row_t parked_z = '0;
  z_row_t exp_z;
  int     mon_k;
  elem_t  mon_xs [MAX_K];
  w_row_t mon_ws [MAX_K];

  logic   stall_mode;
  int     stall_left;
  logic   next_ready;
  int unsigned ready_r;

  mm_top dut_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .start_i    ( start_i    ),
    .k_len_i    ( k_len_i    ),
    .x_i        ( x_i        ),
    .w_i        ( w_i        ),
    .in_valid_i ( in_valid_i ),
    .in_ready_o ( in_ready_o ),
    .z_o        ( z_o        ),
    .z_valid_o  ( z_valid_o  ),
    .z_ready_i  ( z_ready_i  ),
    .busy_o     ( busy_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      stop_with_failure();
    end
  endtask

  task automatic check_z(input z_row_t got, input z_row_t exp);
    if (got !== exp) begin
      $display("ERR z_o got %h expected %h at %0t", got, exp, $time);
      stop_with_failure();
    end
  endtask

  // Wide sums truncated to the accumulator width give the wrapped result
  function automatic z_row_t ref_z_row(input int k, input elem_t xs [MAX_K],
                                       input w_row_t ws [MAX_K]);
    z_row_t z;
    longint s;
    int     j;
    int     b;
    for (j = 0; j < ARRAY_W; j++) begin
      s = 0;
      for (b = 0; b < k; b++) begin
        s = s + longint'(xs[b]) * longint'(ws[b][j]);
      end
      z[j] = acc_t'(s);
    end
    return z;
  endfunction

  task automatic fill_random(input int k);
    int b;
    int j;
    for (b = 0; b < k; b++) begin
      job_xs[b] = elem_t'($random(seed));
      for (j = 0; j < ARRAY_W; j++) begin
        job_ws[b][j] = elem_t'($random(seed));
      end
    end
  endtask

  // Called on a rising edge with the loader idle, returns on the last transfer edge
  task automatic issue_job(input int k);
    int b;
    int gap;
    k_hist.push_back(k);
    for (b = 0; b < k; b++) begin
      x_hist.push_back(job_xs[b]);
      w_hist.push_back(job_ws[b]);
    end
    jobs_issued = jobs_issued + 1;
    start_i <= 1'b1;
    k_len_i <= k_len_t'(k);
    @(posedge clk_i);
    start_i  <= 1'b0;
    job_open = 1'b1;
    for (b = 0; b < k; b++) begin
      gap = ($unsigned($random(seed)) % 4 == 0) ? $unsigned($random(seed)) % 5 : 0;
      repeat (gap) begin
        in_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      in_valid_i <= 1'b1;
      x_i        <= job_xs[b];
      w_i        <= job_ws[b];
      @(negedge clk_i);
      while (!in_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    in_valid_i <= 1'b0;
    job_open   = 1'b0;
  endtask

  // Result sink, mostly ready or with random long stalls
  initial begin
    z_ready_i  = 1'b0;
    stall_left = 0;
    forever begin
      @(negedge clk_i);
      if (!stall_mode) begin
        next_ready = 1'b1;
      end else if (stall_left > 0) begin
        next_ready = 1'b0;
        stall_left = stall_left - 1;
      end else begin
        ready_r = $unsigned($random(seed));
        if (ready_r % 16 == 0) begin
          stall_left = 10 + (ready_r / 16) % 40;
          next_ready = 1'b0;
        end else begin
          next_ready = ready_r[5];
        end
      end
      @(posedge clk_i);
      z_ready_i <= next_ready;
    end
  end

  // Monitor, sampled mid cycle where every signal is settled
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_bit(busy_o, outstanding != 0, "busy_o");
      if (!job_open) begin
        check_bit(in_ready_o, 1'b0, "in_ready_o");
      end
      if (z_parked) begin
        check_bit(z_valid_o, 1'b1, "z_valid_o");
        check_z(z_o, parked_z);
      end
      if (start_i) begin
        outstanding = outstanding + 1;
      end
      z_parked = 1'b0;
      if (z_valid_o && z_ready_i) begin
        if (k_hist.size() == 0) begin
          $display("A result was offered with no job outstanding");
          stop_with_failure();
        end
        mon_k = k_hist.pop_front();
        for (int b = 0; b < mon_k; b++) begin
          mon_xs[b] = x_hist.pop_front();
          mon_ws[b] = w_hist.pop_front();
        end
        exp_z = ref_z_row(mon_k, mon_xs, mon_ws);
        check_z(z_o, exp_z);
        outstanding   = outstanding - 1;
        results_taken = results_taken + 1;
      end else if (z_valid_o) begin
        z_parked = 1'b1;
        parked_z = z_o;
      end
    end
  end

  initial begin
    wait (total_beats > 0);
    repeat (total_beats * 20 + 1000) @(posedge clk_i);
    $display("watchdog expired before all results arrived");
    stop_with_failure();
  end

  initial begin
    seed          = 32'h4a0d382c;
    rst_n_i       = 1'b0;
    start_i       = 1'b0;
    k_len_i       = '0;
    x_i           = '0;
    w_i           = '0;
    in_valid_i    = 1'b0;
    stall_mode    = 1'b0;
    job_open      = 1'b0;
    jobs_issued   = 0;
    for (int i = 0; i < RAND_JOBS + STALL_JOBS; i++) begin
      k_plan[i] = 1 + $unsigned($random(seed)) % 20;
    end
    total_beats = 1 + 255;
    for (int i = 0; i < RAND_JOBS + STALL_JOBS; i++) begin
      total_beats = total_beats + k_plan[i];
    end

    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_bit(in_ready_o, 1'b0, "in_ready_o");
    check_bit(z_valid_o, 1'b0, "z_valid_o");
    check_bit(busy_o, 1'b0, "busy_o");
    @(posedge clk_i);

    // Single beat with negative operands
    job_xs[0]    = -8'sd3;
    job_ws[0][0] = 8'sd7;
    job_ws[0][1] = -8'sd128;
    job_ws[0][2] = 8'sd127;
    job_ws[0][3] = -8'sd1;
    issue_job(1);

    for (int i = 0; i < RAND_JOBS; i++) begin
      fill_random(k_plan[i]);
      issue_job(k_plan[i]);
    end

    stall_mode = 1'b1;
    for (int i = RAND_JOBS; i < RAND_JOBS + STALL_JOBS; i++) begin
      fill_random(k_plan[i]);
      issue_job(k_plan[i]);
    end

    // Longest job, every operand at the negative limit
    for (int b = 0; b < 255; b++) begin
      job_xs[b] = -8'sd128;
      job_ws[b] = {ARRAY_W{-8'sd128}};
    end
    issue_job(255);

    while (results_taken < jobs_issued) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit(busy_o, 1'b0, "busy_o");
    check_bit(in_ready_o, 1'b0, "in_ready_o");
    check_bit(z_valid_o, 1'b0, "z_valid_o");

    if (k_hist.size() != 0 || results_taken != jobs_issued) begin
      $display("Some results are missing at the end of the run");
      stop_with_failure();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
